//--- cache_golden.txt
# port (0 = i, 1 = d), kind (0 read, 1 write, 2 read and write together = no-op)
# word address, write data, expected read data; all three in hex, expected used by reads only
# i port region starts at word 0
0 0 00000004 00000000 00000000
0 0 00000005 00000000 00000000
0 1 00000006 11110006 00000000
0 0 00000006 00000000 11110006
0 0 00000007 00000000 00000000
0 0 00000004 00000000 00000000
0 1 00000024 22220024 00000000
0 0 00000006 00000000 11110006
0 2 00000006 deadbeef 00000000
0 0 00000006 00000000 11110006
0 0 00000024 00000000 22220024
0 1 00000010 33330010 00000000
0 0 00000030 00000000 00000000
0 0 00000010 00000000 33330010
# d port region starts at word 00100000
1 0 00100004 00000000 00000000
1 1 00100004 aaaa0004 00000000
1 1 00100007 aaaa0007 00000000
1 0 00100005 00000000 00000000
1 0 00100004 00000000 aaaa0004
1 0 00100024 00000000 00000000
1 0 00100007 00000000 aaaa0007
1 2 00100007 55555555 00000000
1 0 00100007 00000000 aaaa0007
1 1 0010001c bbbb001c 00000000
1 0 0010003c 00000000 00000000
1 0 0010001c 00000000 bbbb001c

//--- list.f
cache_pkg.sv
l1_cache.sv
mem_arbiter.sv
cache_system.sv
cache_system_asserts.sv
tb_slow_mem.sv
tb_cache_system.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_cache_system -f list.f -o sim_cache
./obj_dir/sim_cache +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
if grep -q "Test FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

//--- tb_cache_system.sv
// reads cache_golden.txt from the run directory; the two port regions must not overlap
`timescale 1ns/1ps

module tb_cache_system import cache_pkg::*; ();

	localparam int clk_period   = 4;
	localparam int transfer_max = 7;	// worst ready latency plus the gap after it
	localparam int op_max       = 4 * transfer_max + 2;	// own miss behind the other port's miss

	typedef struct packed {
		logic [1:0]        kind;	// 0 read, 1 write, 2 read and write
		proc_addr_t        addr;
		logic [word_w-1:0] wdata;
		logic [word_w-1:0] expected;
	} golden_op_t;

	logic      clk;
	logic      proc_reset;
	proc_req_t i_req;
	proc_req_t d_req;
	proc_rsp_t i_rsp;
	proc_rsp_t d_rsp;
	mem_req_t  mem_req;
	mem_rsp_t  mem_rsp;

	golden_op_t      i_ops[$];
	golden_op_t      d_ops[$];
	bit [word_w-1:0] ref_image [bit [proc_addr_w-1:0]];	// every word written so far

	// expected line contents per port, direct-mapped
	bit             line_valid [2][num_lines];
	bit [tag_w-1:0] line_tag   [2][num_lines];

	bit loaded;
	int read_errors;
	int stall_errors;
	int wb_errors;
	int image_errors;
	int golden_errors;

	cache_system cache_system_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.i_req      (i_req),
		.i_rsp      (i_rsp),
		.d_req      (d_req),
		.d_rsp      (d_rsp),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp)
	);

	tb_slow_mem slow_mem (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// --------------------
	// checks
	// --------------------
	function automatic bit word_matches(string name, logic [word_w-1:0] got,
		logic [word_w-1:0] expected);
		if (got !== expected) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
			return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic check_read(input string port_name, input proc_rsp_t rsp,
		input golden_op_t op);
		if (!word_matches($sformatf("%s_rsp.rdata @%h", port_name, op.addr), rsp.rdata,
			op.expected))
			read_errors++;
	endtask

	// a hit answers in the same cycle, a miss raises stall at once
	task automatic check_stall(input string port_name, input proc_rsp_t rsp,
		input bit expect_miss);
		if (rsp.stall !== expect_miss) begin
			$display("FAIL t=%0t %s_rsp.stall got %b expected %b", $time, port_name,
				rsp.stall, expect_miss);
			stall_errors++;
		end
	endtask

	// each word of an evicted line against the reference image
	task automatic check_write_back(input mem_req_t req);
		logic [proc_addr_w-1:0] a;
		logic [word_w-1:0]      expected;
		int                     k;

		for (k = 0; k < line_words; k++) begin
			a        = {req.addr, k[offset_w-1:0]};
			expected = ref_image.exists(a) ? ref_image[a] : '0;
			if (!word_matches($sformatf("mem_req.wdata[%0d] @%h", k, a),
				req.wdata[k*word_w +: word_w], expected))
				wb_errors++;
		end
	endtask

	task automatic check_image();
		foreach (ref_image[a]) begin
			if (!word_matches($sformatf("memory word @%h", a), slow_mem.words[a],
				ref_image[a]))
				image_errors++;
		end
	endtask

	always @(negedge clk) begin
		#(clk_period / 4);	// ready and the bus are settled here
		if (!proc_reset && mem_req.write && mem_rsp.ready)
			check_write_back(mem_req);
	end

	// --------------------
	// stimulus
	// --------------------
	task automatic load_golden();
		int              fd;
		int              got;
		int              fields;
		int              port;
		int              kind;
		logic [31:0]     addr;
		logic [31:0]     wdata;
		logic [31:0]     expected;
		string           line;
		golden_op_t      op;

		fd = $fopen("cache_golden.txt", "r");
		if (fd == 0) begin
			$display("ERROR the golden file cache_golden.txt cannot be opened");
			golden_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				got  = $fgets(line, fd);
				fields = (got > 0) ? $sscanf(line, "%d %d %h %h %h", port, kind, addr, wdata,
					expected) : 0;
				if (fields == 5 && (port > 1 || kind > 2)) begin
					$display("ERROR golden line has a bad port or kind: %s", line);
					golden_errors++;
				end else if (fields == 5) begin
					op.kind     = kind[1:0];
					op.addr     = addr[proc_addr_w-1:0];
					op.wdata    = wdata;
					op.expected = expected;
					if (port == 1)
						d_ops.push_back(op);
					else
						i_ops.push_back(op);
				end
			end
			$fclose(fd);
		end
		if (i_ops.size() + d_ops.size() == 0) begin
			$display("ERROR no operations were read from the golden file");
			golden_errors++;
		end
	endtask

	task automatic drive_req(input bit port, input proc_req_t req);
		if (port)
			d_req = req;
		else
			i_req = req;
	endtask

	task automatic run_op(input bit port, input golden_op_t op);
		proc_req_t req;
		proc_rsp_t rsp;
		bit        expect_miss;

		req.read  = (op.kind != 2'd1);
		req.write = (op.kind != 2'd0);
		req.addr  = op.addr;
		req.wdata = op.wdata;
		// hit when the last access to this index brought in the same tag
		expect_miss = (op.kind != 2'd2) && !(line_valid[port][op.addr.index]
			&& line_tag[port][op.addr.index] == op.addr.tag);
		@(negedge clk);
		drive_req(port, req);
		#(clk_period / 4);
		rsp = port ? d_rsp : i_rsp;
		check_stall(port ? "d" : "i", rsp, expect_miss);
		while (rsp.stall) begin	// held until the miss is served
			@(negedge clk);
			#(clk_period / 4);
			rsp = port ? d_rsp : i_rsp;
		end
		@(posedge clk);	// access completes on this edge
		if (op.kind != 2'd2) begin
			line_valid[port][op.addr.index] = 1'b1;
			line_tag[port][op.addr.index]   = op.addr.tag;
		end
		if (op.kind == 2'd0)
			check_read(port ? "d" : "i", rsp, op);
		else if (op.kind == 2'd1)
			ref_image[op.addr] = op.wdata;
	endtask

	task automatic run_port(input bit port);
		golden_op_t op;
		int         n;
		int         k;

		n = port ? d_ops.size() : i_ops.size();
		for (k = 0; k < n; k++) begin
			op = port ? d_ops[k] : i_ops[k];
			run_op(port, op);
		end
		@(negedge clk);
		drive_req(port, '0);
	endtask

	// --------------------
	// main and watchdog
	// --------------------
	initial begin
		int total;

		i_req      = '0;
		d_req      = '0;
		proc_reset = 1'b1;
		load_golden();
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		proc_reset = 1'b0;
		fork	// both ports at once so the caches fight for the bus
			run_port(1'b0);
			run_port(1'b1);
		join
		repeat (4) @(posedge clk);
		check_image();
		total = read_errors + stall_errors + wb_errors + image_errors + golden_errors
			+ cache_system_i.asserts_i.fail_count;
		$display("errors: read %0d stall %0d wb %0d image %0d golden %0d assert %0d",
			read_errors, stall_errors, wb_errors, image_errors, golden_errors,
			cache_system_i.asserts_i.fail_count);
		if (total == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		int limit;

		wait (loaded);
		limit = (i_ops.size() + d_ops.size()) * op_max * 2 + 40;	// cycles
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles, a port never saw its stall fall", limit);
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- tb_slow_mem.sv
// behavioral line memory for the testbench; all words start at zero, ready comes 1 to 6 cycles late
`timescale 1ns/1ps

module tb_slow_mem import cache_pkg::*; (
	input  logic     clk,
	input  logic     proc_reset,
	input  mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	bit [word_w-1:0] words [bit [proc_addr_w-1:0]];	// word addressed, sparse

	logic [31:0]       rng = 32'hb983_5610;
	logic [31:0]       wait_left;
	logic              busy;
	logic [line_w-1:0] line_buf;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;

		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// --------------------
	// transfers
	// --------------------
	// driven on the falling edge like the other DUT inputs
	always @(negedge clk or posedge proc_reset) begin
		if (proc_reset) begin
			mem_rsp   <= '0;
			busy      <= 1'b0;
			wait_left <= '0;
		end else begin
			mem_rsp.ready <= 1'b0;	// single cycle pulse
			if (!mem_rsp.ready && (mem_req.read || mem_req.write)) begin
				if (!busy) begin
					rng = xorshift32(rng);
					wait_left <= rng % 32'd6;
					busy      <= 1'b1;
				end else if (wait_left == 0) begin
					busy          <= 1'b0;
					mem_rsp.ready <= 1'b1;
					for (int k = 0; k < line_words; k++) begin
						if (mem_req.write)
							words[{mem_req.addr, k[offset_w-1:0]}] = mem_req.wdata[k*word_w +: word_w];
						line_buf[k*word_w +: word_w] = words[{mem_req.addr, k[offset_w-1:0]}];
					end
					mem_rsp.rdata <= line_buf;
				end else begin
					wait_left <= wait_left - 1;
				end
			end
		end
	end

endmodule

//--- cache_system_asserts.sv
// bus and stall properties for cache_system, bound into every instance of it
`timescale 1ns/1ps

module cache_system_asserts import cache_pkg::*; (
	input logic      clk,
	input logic      proc_reset,
	input proc_rsp_t i_rsp,
	input proc_rsp_t d_rsp,
	input mem_req_t  mem_req,
	input mem_rsp_t  mem_rsp,
	input mem_req_t  i_mem_req,
	input mem_req_t  d_mem_req,
	input mem_rsp_t  i_mem_rsp,
	input mem_rsp_t  d_mem_rsp
);

	int fail_count;	// read by the testbench at the end

	// --------------------
	// shared bus
	// --------------------
	assert property (@(posedge clk) disable iff (proc_reset) !(mem_req.read && mem_req.write))
		else begin fail_count++; $error("read and write both high on the memory bus"); end

	assert property (@(posedge clk) disable iff (proc_reset)
		(mem_req.read || mem_req.write) && !mem_rsp.ready |=> $stable(mem_req))
		else begin fail_count++; $error("bus request changed before ready"); end

	// ready only reaches the cache whose request is on the bus
	assert property (@(posedge clk) disable iff (proc_reset)
		!i_mem_rsp.ready || (mem_req == i_mem_req && !d_mem_rsp.ready))
		else begin fail_count++; $error("i side ready while the d request holds the bus"); end

	assert property (@(posedge clk) disable iff (proc_reset)
		!d_mem_rsp.ready || (mem_req == d_mem_req && !i_mem_rsp.ready))
		else begin fail_count++; $error("d side ready while the i request holds the bus"); end

	assert property (@(posedge clk) $fell(proc_reset) |-> !i_rsp.stall && !d_rsp.stall)
		else begin fail_count++; $error("stall high right after reset"); end

endmodule

bind cache_system cache_system_asserts asserts_i (
	.clk        (clk),
	.proc_reset (proc_reset),
	.i_rsp      (i_rsp),
	.d_rsp      (d_rsp),
	.mem_req    (mem_req),
	.mem_rsp    (mem_rsp),
	.i_mem_req  (i_mem_req),
	.d_mem_req  (d_mem_req),
	.i_mem_rsp  (i_mem_rsp),
	.d_mem_rsp  (d_mem_rsp)
);

//--- cache_system.sv
// two l1 caches on one slow memory bus; the caches are not coherent with each other
`timescale 1ns/1ps

module cache_system import cache_pkg::*; (
	input  logic      clk,
	input  logic      proc_reset,
	input  proc_req_t i_req,
	output proc_rsp_t i_rsp,
	input  proc_req_t d_req,
	output proc_rsp_t d_rsp,
	output mem_req_t  mem_req,
	input  mem_rsp_t  mem_rsp
);

	mem_req_t i_mem_req;
	mem_req_t d_mem_req;
	mem_rsp_t i_mem_rsp;
	mem_rsp_t d_mem_rsp;

	// --------------------
	// caches
	// --------------------
	l1_cache i_cache (
		.clk        (clk),
		.proc_reset (proc_reset),
		.req        (i_req),
		.rsp        (i_rsp),
		.mem_req    (i_mem_req),
		.mem_rsp    (i_mem_rsp)
	);

	l1_cache d_cache (
		.clk        (clk),
		.proc_reset (proc_reset),
		.req        (d_req),
		.rsp        (d_rsp),
		.mem_req    (d_mem_req),
		.mem_rsp    (d_mem_rsp)
	);

	// shared bus
	mem_arbiter arbiter (
		.clk        (clk),
		.proc_reset (proc_reset),
		.i_mem_req  (i_mem_req),
		.d_mem_req  (d_mem_req),
		.i_mem_rsp  (i_mem_rsp),
		.d_mem_rsp  (d_mem_rsp),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp)
	);

endmodule

//--- mem_arbiter.sv
// round-robin arbiter for two caches; a grant lasts as long as its owner keeps a request up
`timescale 1ns/1ps

module mem_arbiter import cache_pkg::*; (
	input  logic     clk,
	input  logic     proc_reset,
	input  mem_req_t i_mem_req,
	input  mem_req_t d_mem_req,
	output mem_rsp_t i_mem_rsp,
	output mem_rsp_t d_mem_rsp,
	output mem_req_t mem_req,
	input  mem_rsp_t mem_rsp
);

	logic busy_q;	// a grant was live last cycle
	logic owner_q;	// 0 = i side, 1 = d side
	logic last_q;	// winner of the most recent new grant

	logic i_want;
	logic d_want;
	logic owner_want;
	logic hold;
	logic pick_d;
	logic grant_d;
	logic grant_valid;

	assign i_want = i_mem_req.read | i_mem_req.write;
	assign d_want = d_mem_req.read | d_mem_req.write;

	// --------------------
	// grant selection
	// --------------------
	assign owner_want = owner_q ? d_want : i_want;
	assign hold       = busy_q && owner_want;	// whole miss under one grant

	// contention alternates away from the last winner
	assign pick_d = (i_want && d_want) ? ~last_q : d_want;

	assign grant_d     = hold ? owner_q : pick_d;
	assign grant_valid = hold || i_want || d_want;

	always_ff @(posedge clk or posedge proc_reset) begin
		if (proc_reset) begin
			busy_q  <= 1'b0;
			owner_q <= 1'b0;
			last_q  <= 1'b1;	// i side wins the first tie
		end else begin
			busy_q  <= grant_valid;
			owner_q <= grant_d;
			if (grant_valid && !hold)
				last_q <= pick_d;
		end
	end

	// --------------------
	// bus steering
	// --------------------
	always_comb begin
		if (!grant_valid)
			mem_req = '0;	// idle bus
		else if (grant_d)
			mem_req = d_mem_req;
		else
			mem_req = i_mem_req;
	end

	// ready goes to the owner only, line data is shared
	assign i_mem_rsp.ready = mem_rsp.ready && grant_valid && !grant_d;
	assign i_mem_rsp.rdata = mem_rsp.rdata;
	assign d_mem_rsp.ready = mem_rsp.ready && grant_valid && grant_d;
	assign d_mem_rsp.rdata = mem_rsp.rdata;

endmodule

//--- l1_cache.sv
// direct-mapped write-back cache; caller must hold req stable while stall is high
`timescale 1ns/1ps

module l1_cache import cache_pkg::*; (
	input  logic      clk,
	input  logic      proc_reset,
	input  proc_req_t req,
	output proc_rsp_t rsp,
	output mem_req_t  mem_req,
	input  mem_rsp_t  mem_rsp
);

	// --------------------
	// line storage
	// --------------------
	logic [num_lines-1:0] valid_q;
	logic [num_lines-1:0] dirty_q;
	logic [tag_w-1:0]     tag_mem  [num_lines];
	logic [line_w-1:0]    data_mem [num_lines];

	miss_state_t state_q;
	miss_state_t state_d;

	proc_addr_t  addr;
	cache_line_t cur;	// line selected by the request index
	logic        access;
	logic        hit;
	logic        wr_hit;
	logic        fill;

	assign addr = req.addr;

	assign cur.valid = valid_q[addr.index];
	assign cur.dirty = dirty_q[addr.index];
	assign cur.tag   = tag_mem[addr.index];
	assign cur.data  = data_mem[addr.index];

	assign access = req.read ^ req.write;	// both high does nothing
	assign hit    = cur.valid && (cur.tag == addr.tag);
	assign wr_hit = (state_q == idle) && req.write && !req.read && hit;
	assign fill   = (state_q == refill) && mem_rsp.ready;

	// --------------------
	// miss fsm
	// --------------------
	always_comb begin
		state_d       = state_q;
		rsp.stall     = 1'b0;
		rsp.rdata     = cur.data[addr.offset*word_w +: word_w];
		mem_req.read  = 1'b0;
		mem_req.write = 1'b0;
		mem_req.addr  = '0;
		mem_req.wdata = cur.data;	// only meaningful during write back

		case (state_q)
			idle: begin
				if (access && !hit) begin
					rsp.stall = 1'b1;
					// victim must go out first if modified
					if (cur.valid && cur.dirty)
						state_d = write_back;
					else
						state_d = refill;
				end
			end
			write_back: begin
				rsp.stall     = 1'b1;
				mem_req.write = 1'b1;
				mem_req.addr  = {cur.tag, addr.index};	// stored tag
				if (mem_rsp.ready)
					state_d = refill;
			end
			refill: begin
				rsp.stall    = 1'b1;
				mem_req.read = 1'b1;
				mem_req.addr = {addr.tag, addr.index};	// requested tag
				if (mem_rsp.ready)
					state_d = idle;
			end
			default: begin
				state_d = idle;
			end
		endcase
	end

	always_ff @(posedge clk or posedge proc_reset) begin
		if (proc_reset) begin
			state_q <= idle;
		end else begin
			state_q <= state_d;
		end
	end

	// --------------------
	// line status bits
	// --------------------
	always_ff @(posedge clk or posedge proc_reset) begin
		if (proc_reset) begin
			valid_q <= '0;	// every line starts empty
			dirty_q <= '0;
		end else if (fill) begin
			valid_q[addr.index] <= 1'b1;
			dirty_q[addr.index] <= 1'b0;	// fresh line is clean
		end else if (wr_hit) begin
			dirty_q[addr.index] <= 1'b1;
		end
	end

	// tags and data
	always_ff @(posedge clk) begin
		if (fill) begin
			tag_mem[addr.index]  <= addr.tag;
			data_mem[addr.index] <= mem_rsp.rdata;
		end else if (wr_hit) begin
			// merge one word, rest of the line untouched
			data_mem[addr.index][addr.offset*word_w +: word_w] <= req.wdata;
		end
	end

endmodule

//--- cache_pkg.sv
// shared cache types and geometry; word addresses only, no byte enables, lines are 4 words
package cache_pkg;

	// --------------------
	// geometry
	// --------------------
	localparam int word_w      = 32;
	localparam int line_words  = 4;
	localparam int line_w      = word_w * line_words;	// 128
	localparam int num_lines   = 8;
	localparam int proc_addr_w = 30;	// word address from the processor
	localparam int offset_w    = $clog2(line_words);
	localparam int index_w     = $clog2(num_lines);
	localparam int mem_addr_w  = proc_addr_w - offset_w;	// line address on the bus
	localparam int tag_w       = proc_addr_w - index_w - offset_w;

	// --------------------
	// processor side
	// --------------------
	typedef struct packed {
		logic [tag_w-1:0]    tag;
		logic [index_w-1:0]  index;
		logic [offset_w-1:0] offset;	// word within the line
	} proc_addr_t;

	// read and write both high is a no-op
	typedef struct packed {
		logic              read;
		logic              write;
		proc_addr_t        addr;
		logic [word_w-1:0] wdata;
	} proc_req_t;

	typedef struct packed {
		logic              stall;
		logic [word_w-1:0] rdata;
	} proc_rsp_t;

	// --------------------
	// memory side
	// --------------------
	// levels held until ready
	typedef struct packed {
		logic                  read;
		logic                  write;
		logic [mem_addr_w-1:0] addr;
		logic [line_w-1:0]     wdata;
	} mem_req_t;

	// ready is a single cycle pulse
	typedef struct packed {
		logic              ready;
		logic [line_w-1:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic              valid;
		logic              dirty;
		logic [tag_w-1:0]  tag;
		logic [line_w-1:0] data;
	} cache_line_t;

	typedef enum logic [1:0] {
		idle,
		write_back,
		refill
	} miss_state_t;

endpackage
